//--- ethFramePkg.sv
// Ethernet wire-format types and constants, imported by the transmit MAC and its testbench
package ethFramePkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  typedef logic [3:0]  nibble_t;    // One MII transfer
  typedef logic [7:0]  byte_t;      // Payload byte from the host
  typedef logic [47:0] macAddr_t;   // Station address
  typedef logic [15:0] lenField_t;  // Length/type field

  //////////////////////////////
  // Frame delimiters
  //////////////////////////////

  // Preamble pattern, each nibble of 0x55 on the wire
  localparam nibble_t PreambleNibble = 4'h5;

  // Second nibble of the SFD byte 0xD5
  localparam nibble_t SfdNibble = 4'hD;

  // Length of the preamble state, SFD byte follows
  localparam int PreambleNibbles = 14;

  //////////////////////////////
  // Frame check sequence
  //////////////////////////////

  // IEEE 802.3 generator, MSB-first form
  localparam logic [31:0] CrcPoly = 32'h04C1_1DB7;

  // Register value after a frame and its own FCS are folded in
  localparam logic [31:0] CrcResidue = 32'hC704_DD7B;

endpackage

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tbTxMac -o simTxMac \
  && ./obj_dir/simTxMac \
  || exit 1

//--- tbTxMac.sv
// Testbench for the transmit MAC, drives frames into txMacTop and checks the MII stream it sends
`timescale 1ns/1ns

module tbTxMac;

  import ethFramePkg::*;

  localparam int ClkPeriod     = 20;
  localparam int ResetCycles   = 10;
  localparam int IpgCycles     = 24;  // Same as the DUT defaults
  localparam int MinFrameBytes = 64;
  localparam int MaxPayload    = 60;
  localparam int HeadNibbles   = PreambleNibbles + 2;  // Preamble state plus SFD byte
  localparam int MaxFrameNibbles = HeadNibbles + 2 * (14 + MaxPayload) + 8;
  localparam int NumFrames     = 9;
  localparam int WatchdogNs    =
    (ResetCycles + 20 + NumFrames * (MaxFrameNibbles + IpgCycles + 50)) * ClkPeriod;

  logic      MTxClk;
  logic      Resetn;
  logic      TxStartFrm;
  logic      TxEndFrm;
  logic      TxUnderRun;
  logic      Pad;
  byte_t     TxData;
  macAddr_t  MacAddress;
  macAddr_t  DaAddress;
  lenField_t PayloadLength;
  nibble_t   MTxD;
  logic      MTxEn;
  logic      MTxErr;
  logic      TxDone;
  logic      TxAbort;
  logic      TxUsedData;

  // Expected stream, one entry per frame in the small queues
  nibble_t expQ[$];
  int      expLenQ[$];
  int      expUsedQ[$];
  bit      expCutQ[$];
  byte_t   payload[$];
  nibble_t frameNibs[$];  // Nibbles of the frame on the wire

  int   framesSent    = 0;
  int   framesDone    = 0;
  int   lastFrameNibs = 0;
  int   usedCnt       = 0;
  int   errCnt        = 0;
  int   gapCnt        = 0;
  logic wasEn         = 1'b0;
  logic lastErr       = 1'b0;
  logic doneBefore    = 1'b0;

  txMacTop txMacTop_inst (
    .MTxClk        (MTxClk),
    .Resetn        (Resetn),
    .TxStartFrm    (TxStartFrm),
    .TxEndFrm      (TxEndFrm),
    .TxUnderRun    (TxUnderRun),
    .Pad           (Pad),
    .TxData        (TxData),
    .MacAddress    (MacAddress),
    .DaAddress     (DaAddress),
    .PayloadLength (PayloadLength),
    .MTxD          (MTxD),
    .MTxEn         (MTxEn),
    .MTxErr        (MTxErr),
    .TxDone        (TxDone),
    .TxAbort       (TxAbort),
    .TxUsedData    (TxUsedData)
  );

  initial
  begin
    MTxClk = 1'b0;
    forever #(ClkPeriod / 2) MTxClk = ~MTxClk;
  end

  task automatic stopWithMessage(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    stopWithMessage($sformatf("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                              $time, name, expected, actual));
  endtask

  initial
  begin
    #(WatchdogNs);
    stopWithMessage("Watchdog expired before all frames were sent");
  end

  //////////////////////////////
  // Reference frame model
  //////////////////////////////

  // Reflected CRC-32, one wire nibble with bit 0 first
  function automatic logic [31:0] crcStep(input logic [31:0] crcIn, input nibble_t nib);
    logic [31:0] c;
    c = crcIn;
    for (int i = 0; i < 4; i++)
    begin
      if (c[0] ^ nib[i])
        c = (c >> 1) ^ 32'hEDB8_8320;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  function automatic logic [31:0] bitReverse32(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++)
      r[i] = v[31 - i];
    return r;
  endfunction

  task automatic buildExpected(input macAddr_t da, input macAddr_t sa, input lenField_t lenF,
                               input bit padIt, input int cutAt);
    byte_t       bytes[$];
    byte_t       bt;
    logic [31:0] crc;
    logic [31:0] fcs;
    int          nSent;
    for (int i = 0; i < PreambleNibbles + 1; i++)
      expQ.push_back(PreambleNibble);
    expQ.push_back(SfdNibble);
    for (int b = 5; b >= 0; b--)
      bytes.push_back(da[8 * b +: 8]);  // MSB first
    for (int b = 5; b >= 0; b--)
      bytes.push_back(sa[8 * b +: 8]);
    bytes.push_back(lenF[15:8]);
    bytes.push_back(lenF[7:0]);
    nSent = (cutAt >= 0) ? cutAt : payload.size();
    for (int i = 0; i < nSent; i++)
      bytes.push_back(payload[i]);
    while (padIt && cutAt < 0 && bytes.size() < MinFrameBytes - 4)
      bytes.push_back(8'h00);
    crc = '1;
    foreach (bytes[i])
    begin
      bt = bytes[i];
      expQ.push_back(bt[3:0]);
      expQ.push_back(bt[7:4]);
      crc = crcStep(crc, bt[3:0]);
      crc = crcStep(crc, bt[7:4]);
    end
    if (cutAt >= 0)
    begin
      expQ.push_back(4'h0);  // DataLow nibble of the missing byte
      expLenQ.push_back(HeadNibbles + 2 * bytes.size() + 1);
    end
    else
    begin
      fcs = ~crc;
      for (int i = 0; i < 8; i++)
        expQ.push_back(fcs[4 * i +: 4]);
      expLenQ.push_back(HeadNibbles + 2 * bytes.size() + 8);
    end
    expUsedQ.push_back(nSent);
    expCutQ.push_back(cutAt >= 0);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Negative cutAt means no under-run
  task automatic driveFrame(input int len, input bit padIt, input int cutAt, input bit fromIdle);
    macAddr_t da;
    macAddr_t sa;
    int       idx;
    int       waitCnt;
    da = {16'($urandom), $urandom};
    sa = {16'($urandom), $urandom};
    payload.delete();
    for (int i = 0; i < len; i++)
      payload.push_back(8'($urandom));
    buildExpected(da, sa, 16'(len), padIt, cutAt);
    framesSent++;
    DaAddress     = da;
    MacAddress    = sa;
    PayloadLength = 16'(len);
    Pad           = padIt;
    TxData        = payload[0];
    TxEndFrm      = (len == 1);
    TxUnderRun    = 1'b0;
    TxStartFrm    = 1'b1;
    idx     = 0;
    waitCnt = 0;
    while (idx < len)
    begin
      @(negedge MTxClk);
      waitCnt++;
      if (fromIdle && waitCnt <= 2)  // Enable two edges after acceptance
        assert (MTxEn == (waitCnt == 2))
          else reportMismatch("MTxEn", 32'(waitCnt == 2), 32'(MTxEn));
      if (TxUsedData)
      begin
        TxStartFrm = 1'b0;
        idx++;
        if (idx == cutAt)
        begin
          TxUnderRun = 1'b1;
          TxData     = 8'h00;
          TxEndFrm   = 1'b0;
          @(negedge MTxClk);
          TxUnderRun = 1'b0;
          idx        = len;
        end
        else if (idx < len)
        begin
          TxData   = payload[idx];
          TxEndFrm = (idx == len - 1);
        end
      end
    end
    TxEndFrm = 1'b0;
  endtask

  task automatic waitForIdle();
    while (framesDone < framesSent)
      @(negedge MTxClk);
    repeat (IpgCycles + 4) @(negedge MTxClk);
  endtask

  task automatic checkIdleOutputs();
    assert (MTxD == 4'h0) else reportMismatch("MTxD", 0, 32'(MTxD));
    assert (!MTxEn) else reportMismatch("MTxEn", 0, 32'(MTxEn));
    assert (!MTxErr) else reportMismatch("MTxErr", 0, 32'(MTxErr));
    assert (!TxDone) else reportMismatch("TxDone", 0, 32'(TxDone));
    assert (!TxAbort) else reportMismatch("TxAbort", 0, 32'(TxAbort));
    assert (!TxUsedData) else reportMismatch("TxUsedData", 0, 32'(TxUsedData));
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  task automatic openFrame();
    if (expLenQ.size() == 0)
      stopWithMessage("MTxEn went high although no frame was requested");
    if (framesDone > 0)
      assert (gapCnt >= IpgCycles)
        else reportMismatch("MTxEn low cycles between frames", IpgCycles, gapCnt);
    assert (!TxDone) else reportMismatch("TxDone", 0, 32'(TxDone));  // Cleared on acceptance
    assert (!TxAbort) else reportMismatch("TxAbort", 0, 32'(TxAbort));
  endtask

  task automatic closeFrame();
    int          expLen;
    int          expUsed;
    bit          cut;
    logic [31:0] crc;
    expLen  = expLenQ.pop_front();
    expUsed = expUsedQ.pop_front();
    cut     = expCutQ.pop_front();
    assert (frameNibs.size() == expLen)
      else reportMismatch("frame nibble count", expLen, frameNibs.size());
    assert (usedCnt == expUsed) else reportMismatch("TxUsedData pulses", expUsed, usedCnt);
    if (cut)
    begin
      assert (errCnt == 1 && lastErr)
        else stopWithMessage("MTxErr was not one pulse on the last nibble of the cut frame");
      assert (TxAbort) else reportMismatch("TxAbort", 1, 32'(TxAbort));
      assert (!TxDone) else reportMismatch("TxDone", 0, 32'(TxDone));
    end
    else
    begin
      assert (errCnt == 0) else reportMismatch("MTxErr cycles", 0, errCnt);
      assert (TxDone && !doneBefore)
        else stopWithMessage("TxDone did not rise on the edge where MTxEn fell");
      assert (!TxAbort) else reportMismatch("TxAbort", 0, 32'(TxAbort));
      crc = '1;
      for (int i = HeadNibbles; i < frameNibs.size(); i++)
        crc = crcStep(crc, frameNibs[i]);
      assert (crc == bitReverse32(CrcResidue))
        else reportMismatch("CRC residue", bitReverse32(CrcResidue), crc);
    end
    lastFrameNibs = frameNibs.size();
    frameNibs.delete();
    usedCnt = 0;
    errCnt  = 0;
    gapCnt  = 1;  // This cycle is already low
    framesDone++;
  endtask

  task automatic expectNibble();
    nibble_t expNib;
    if (expQ.size() == 0)
      stopWithMessage("MTxEn was high for more nibbles than the frames hold");
    expNib = expQ.pop_front();
    assert (MTxD == expNib) else reportMismatch("MTxD", 32'(expNib), 32'(MTxD));
    frameNibs.push_back(MTxD);
    if (MTxErr)
    begin
      errCnt++;
      assert (TxAbort) else reportMismatch("TxAbort", 1, 32'(TxAbort));  // Rises with MTxErr
    end
    lastErr    = MTxErr;
    doneBefore = TxDone;
  endtask

  // Outputs change on the rising edge, so they are read on the falling one
  always @(negedge MTxClk)
  begin
    if (Resetn)
    begin
      if (TxUsedData)
        usedCnt++;
      if (MTxEn)
      begin
        if (!wasEn)
          openFrame();
        expectNibble();
      end
      else
      begin
        assert (!MTxErr) else reportMismatch("MTxErr", 0, 32'(MTxErr));
        if (wasEn)
          closeFrame();
        else
          gapCnt++;
      end
      wasEn = MTxEn;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    void'($urandom(89));
    Resetn        = 1'b0;
    TxStartFrm    = 1'b0;
    TxEndFrm      = 1'b0;
    TxUnderRun    = 1'b0;
    Pad           = 1'b0;
    TxData        = '0;
    MacAddress    = '0;
    DaAddress     = '0;
    PayloadLength = '0;
    repeat (ResetCycles) @(negedge MTxClk);
    checkIdleOutputs();
    Resetn = 1'b1;
    repeat (5)
    begin
      @(negedge MTxClk);
      checkIdleOutputs();
    end

    driveFrame($urandom_range(1, MaxPayload), 1'b0, -1, 1'b1);
    waitForIdle();

    // Short payload with and without zero fill
    driveFrame(10, 1'b1, -1, 1'b1);
    waitForIdle();
    assert (lastFrameNibs == HeadNibbles + 8 + 2 * (MinFrameBytes - 4))
      else reportMismatch("padded frame nibbles", HeadNibbles + 8 + 2 * (MinFrameBytes - 4),
                          lastFrameNibs);
    driveFrame(10, 1'b0, -1, 1'b1);
    waitForIdle();
    assert (lastFrameNibs == HeadNibbles + 8 + 2 * 24)
      else reportMismatch("unpadded frame nibbles", HeadNibbles + 8 + 2 * 24, lastFrameNibs);

    // Source runs dry at byte 7
    driveFrame(20, 1'b0, 7, 1'b1);
    waitForIdle();
    assert (TxAbort && !TxDone)
      else stopWithMessage("TxAbort or TxDone changed before the next frame was accepted");
    driveFrame($urandom_range(1, MaxPayload), 1'($urandom_range(0, 1)), -1, 1'b1);
    waitForIdle();

    // Start held high across frames
    repeat (4)
      driveFrame($urandom_range(1, MaxPayload), 1'($urandom_range(0, 1)), -1, 1'b0);
    waitForIdle();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- txCrc32.sv
// Nibble-wide CRC-32 of the transmit MAC: accumulates the frame and then shifts out its FCS
`timescale 1ns/1ns

module txCrc32 (
  input  logic                 MTxClk,
  input  logic                 Resetn,
  input  txStatePkg::txState_t state,
  input  ethFramePkg::nibble_t txNibble,
  output ethFramePkg::nibble_t fcsNibble
);

  import ethFramePkg::*;
  import txStatePkg::*;

  logic [31:0] crc;

  // One MII nibble, bit 0 first as on the wire
  function automatic logic [31:0] foldNibble(input logic [31:0] crcIn, input nibble_t data);
    logic [31:0] acc;
    logic        fb;
    acc = crcIn;
    for (int i = 0; i < 4; i++)
    begin
      fb  = acc[31] ^ data[i];
      acc = {acc[30:0], 1'b0} ^ (fb ? CrcPoly : 32'h0);
    end
    return acc;
  endfunction

  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
      crc <= '1;
    else
      case (state)
        Idle, Preamble, Sfd:
          crc <= '1;  // Preset before the first address nibble
        DestAddr, SrcAddr, LenField, DataLow, DataHigh, Pad:
          crc <= foldNibble(crc, txNibble);
        Fcs:
          crc <= {crc[27:0], 4'h0};  // Next FCS nibble to the top
        default:
          crc <= crc;
      endcase
  end

  // Top bits inverted and reversed so crc[31] leaves first
  assign fcsNibble = ~{crc[28], crc[29], crc[30], crc[31]};

endmodule

//--- txFieldSerializer.sv
// Transmit nibble mux of the MAC: holds the header fields of a frame and picks the nibble per state
`timescale 1ns/1ns

module txFieldSerializer (
  input  logic                   MTxClk,
  input  logic                   Resetn,
  input  txStatePkg::txState_t   state,
  input  txStatePkg::nibCnt_t    nibCnt,
  input  ethFramePkg::byte_t     TxData,
  input  ethFramePkg::macAddr_t  MacAddress,
  input  ethFramePkg::macAddr_t  DaAddress,
  input  ethFramePkg::lenField_t PayloadLength,
  input  ethFramePkg::nibble_t   fcsNibble,
  output ethFramePkg::nibble_t   txNibble
);

  import ethFramePkg::*;
  import txStatePkg::*;

  macAddr_t   daReg;
  macAddr_t   saReg;
  lenField_t  lenReg;
  byte_t      hdrByte;    // Header byte under the nibble counter
  logic [5:0] addrShift;  // Bit offset of that byte in an address
  logic [3:0] lenShift;

  // Fields follow the inputs until the frame leaves Idle
  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
    begin
      daReg  <= '0;
      saReg  <= '0;
      lenReg <= '0;
    end
    else if (state == Idle)
    begin
      daReg  <= DaAddress;
      saReg  <= MacAddress;
      lenReg <= PayloadLength;
    end
  end

  // Most significant byte goes first
  assign addrShift = 6'd40 - {nibCnt[3:1], 3'b000};
  assign lenShift  = nibCnt[1] ? 4'd0 : 4'd8;

  always_comb
  begin
    case (state)
      DestAddr: hdrByte = byte_t'(daReg >> addrShift);
      SrcAddr:  hdrByte = byte_t'(saReg >> addrShift);
      default:  hdrByte = byte_t'(lenReg >> lenShift);
    endcase
  end

  //////////////////////////////
  // Nibble per state
  //////////////////////////////

  always_comb
  begin
    case (state)
      Preamble:
        txNibble = PreambleNibble;
      Sfd:
        txNibble = nibCnt[0] ? SfdNibble : PreambleNibble;
      DestAddr, SrcAddr, LenField:
        txNibble = nibCnt[0] ? hdrByte[7:4] : hdrByte[3:0];  // Low nibble first
      DataLow:
        txNibble = TxData[3:0];
      DataHigh:
        txNibble = TxData[7:4];
      Fcs:
        txNibble = fcsNibble;
      default:
        txNibble = '0;  // Idle, gap and zero fill
    endcase
  end

endmodule

//--- txFrameFsm.sv
// Frame sequencing FSM of the transmit MAC: steps through the fields and decides pad, gap and abort
`timescale 1ns/1ns

module txFrameFsm #(
  parameter int IpgCycles     = 24,
  parameter int MinFrameBytes = 64
) (
  input  logic                 MTxClk,
  input  logic                 Resetn,
  input  logic                 TxStartFrm,
  input  logic                 TxEndFrm,
  input  logic                 TxUnderRun,
  input  logic                 Pad,
  output txStatePkg::txState_t state,
  output txStatePkg::nibCnt_t  nibCnt,
  output logic                 byteTaken,
  output logic                 frameDone,
  output logic                 frameAbort
);

  import ethFramePkg::*;
  import txStatePkg::*;

  // Frame bytes between SFD and FCS once padded
  localparam byteCnt_t PadTarget = byteCnt_t'(MinFrameBytes - 4);
  localparam byteCnt_t GapLast   = byteCnt_t'(IpgCycles - 1);
  localparam nibCnt_t  PreLast   = nibCnt_t'(PreambleNibbles - 1);

  txState_t nextState;
  byteCnt_t byteCnt;
  byteCnt_t byteCntNext;  // Count once the current byte is out
  logic     padEn;        // Pad input captured at acceptance
  logic     byteDone;

  assign byteCntNext = byteCnt + 1'b1;

  // Header and pad bytes end on their odd nibble
  assign byteDone = ((state == DestAddr || state == SrcAddr || state == LenField ||
                      state == txStatePkg::Pad) && nibCnt[0]) || state == DataHigh;

  assign byteTaken  = (state == DataHigh);
  assign frameAbort = (state == DataLow) && TxUnderRun;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb
  begin
    nextState = state;
    case (state)
      Idle:
        if (TxStartFrm)
          nextState = Preamble;
      Ipg:
        if (byteCnt == GapLast)
          nextState = Idle;
      Preamble:
        if (nibCnt == PreLast)
          nextState = Sfd;
      Sfd:
        if (nibCnt == 4'd1)
          nextState = DestAddr;
      DestAddr:
        if (nibCnt == 4'd11)  // Six bytes
          nextState = SrcAddr;
      SrcAddr:
        if (nibCnt == 4'd11)
          nextState = LenField;
      LenField:
        if (nibCnt == 4'd3)
          nextState = DataLow;
      DataLow:
        if (TxUnderRun)
          nextState = Ipg;  // Truncate, no FCS
        else
          nextState = DataHigh;
      DataHigh:
        if (!TxEndFrm)
          nextState = DataLow;
        else if (padEn && byteCntNext < PadTarget)
          nextState = txStatePkg::Pad;
        else
          nextState = Fcs;
      txStatePkg::Pad:
        if (nibCnt[0] && byteCntNext >= PadTarget)
          nextState = Fcs;
      Fcs:
        if (nibCnt == 4'd7)
          nextState = Ipg;
      default:
        nextState = Idle;
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
      state <= Idle;
    else
      state <= nextState;
  end

  // Restarts on every state change; in Pad only bit 0 is looked at
  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
      nibCnt <= '0;
    else if (nextState != state)
      nibCnt <= '0;
    else
      nibCnt <= nibCnt + 1'b1;
  end

  // Byte count during the frame, cycle count during the gap
  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
      byteCnt <= '0;
    else if (nextState == Ipg && state != Ipg)
      byteCnt <= '0;
    else if (state == Sfd)
      byteCnt <= '0;
    else if (byteDone || state == Ipg)
      byteCnt <= byteCntNext;
  end

  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
      padEn <= 1'b0;
    else if (state == Idle && TxStartFrm)
      padEn <= Pad;
  end

  // High in the first gap cycle after a complete FCS
  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
      frameDone <= 1'b0;
    else
      frameDone <= (state == Fcs) && (nibCnt == 4'd7);
  end

endmodule

//--- txMacTop.sv
// Top level of the full-duplex Ethernet transmit MAC, the block to instantiate in a system
`timescale 1ns/1ns

module txMacTop #(
  parameter int IpgCycles     = 24,  // Gap length in MTxClk cycles
  parameter int MinFrameBytes = 64   // Minimum frame, FCS included
) (
  input  logic                   MTxClk,
  input  logic                   Resetn,
  input  logic                   TxStartFrm,
  input  logic                   TxEndFrm,
  input  logic                   TxUnderRun,
  input  logic                   Pad,
  input  ethFramePkg::byte_t     TxData,
  input  ethFramePkg::macAddr_t  MacAddress,
  input  ethFramePkg::macAddr_t  DaAddress,
  input  ethFramePkg::lenField_t PayloadLength,
  output ethFramePkg::nibble_t   MTxD,
  output logic                   MTxEn,
  output logic                   MTxErr,
  output logic                   TxDone,
  output logic                   TxAbort,
  output logic                   TxUsedData
);

  import ethFramePkg::*;
  import txStatePkg::*;

  txState_t state;
  nibCnt_t  nibCnt;
  nibble_t  txNibble;
  nibble_t  fcsNibble;
  logic     byteTaken;
  logic     frameDone;
  logic     frameAbort;

  txFrameFsm #(
    .IpgCycles     (IpgCycles),
    .MinFrameBytes (MinFrameBytes)
  ) fsmInst (
    .MTxClk     (MTxClk),
    .Resetn     (Resetn),
    .TxStartFrm (TxStartFrm),
    .TxEndFrm   (TxEndFrm),
    .TxUnderRun (TxUnderRun),
    .Pad        (Pad),
    .state      (state),
    .nibCnt     (nibCnt),
    .byteTaken  (byteTaken),
    .frameDone  (frameDone),
    .frameAbort (frameAbort)
  );

  txFieldSerializer serInst (
    .MTxClk        (MTxClk),
    .Resetn        (Resetn),
    .state         (state),
    .nibCnt        (nibCnt),
    .TxData        (TxData),
    .MacAddress    (MacAddress),
    .DaAddress     (DaAddress),
    .PayloadLength (PayloadLength),
    .fcsNibble     (fcsNibble),
    .txNibble      (txNibble)
  );

  // FCS comes back into the nibble mux
  txCrc32 crcInst (
    .MTxClk    (MTxClk),
    .Resetn    (Resetn),
    .state     (state),
    .txNibble  (txNibble),
    .fcsNibble (fcsNibble)
  );

  txOutputRegs outInst (
    .MTxClk     (MTxClk),
    .Resetn     (Resetn),
    .state      (state),
    .txNibble   (txNibble),
    .byteTaken  (byteTaken),
    .frameDone  (frameDone),
    .frameAbort (frameAbort),
    .TxStartFrm (TxStartFrm),
    .MTxD       (MTxD),
    .MTxEn      (MTxEn),
    .MTxErr     (MTxErr),
    .TxDone     (TxDone),
    .TxAbort    (TxAbort),
    .TxUsedData (TxUsedData)
  );

endmodule

//--- txOutputRegs.sv
// Output stage of the transmit MAC: registered MII signals toward the PHY and status toward the host
`timescale 1ns/1ns

module txOutputRegs (
  input  logic                 MTxClk,
  input  logic                 Resetn,
  input  txStatePkg::txState_t state,
  input  ethFramePkg::nibble_t txNibble,
  input  logic                 byteTaken,
  input  logic                 frameDone,
  input  logic                 frameAbort,
  input  logic                 TxStartFrm,
  output ethFramePkg::nibble_t MTxD,
  output logic                 MTxEn,
  output logic                 MTxErr,
  output logic                 TxDone,
  output logic                 TxAbort,
  output logic                 TxUsedData
);

  import txStatePkg::*;

  logic sending;   // State drives a nibble onto the wire
  logic accepted;  // New frame taken this cycle

  assign sending = state inside {Preamble, Sfd, DestAddr, SrcAddr, LenField,
                                 DataLow, DataHigh, Pad, Fcs};
  assign accepted = (state == Idle) && TxStartFrm;

  //////////////////////////////
  // PHY side
  //////////////////////////////

  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
    begin
      MTxD   <= '0;
      MTxEn  <= 1'b0;
      MTxErr <= 1'b0;
    end
    else
    begin
      MTxD   <= txNibble;
      MTxEn  <= sending;
      MTxErr <= frameAbort;  // Lines up with the final nibble
    end
  end

  // Host side, status levels held until the next acceptance
  always_ff @(posedge MTxClk or negedge Resetn)
  begin
    if (!Resetn)
    begin
      TxUsedData <= 1'b0;
      TxDone     <= 1'b0;
      TxAbort    <= 1'b0;
    end
    else
    begin
      TxUsedData <= byteTaken;
      if (accepted)
        TxDone <= 1'b0;
      else if (frameDone)
        TxDone <= 1'b1;
      if (accepted)
        TxAbort <= 1'b0;
      else if (frameAbort)
        TxAbort <= 1'b1;
    end
  end

endmodule

//--- txStatePkg.sv
// Transmit controller state and counter types, shared by the MAC blocks that follow the FSM
package txStatePkg;

  // One state per field on the wire, plus the two quiet states
  typedef enum logic [3:0] {
    Idle,
    Ipg,       // Inter-packet gap
    Preamble,
    Sfd,
    DestAddr,
    SrcAddr,
    LenField,
    DataLow,   // Payload byte, bits 3:0
    DataHigh,  // Payload byte, bits 7:4
    Pad,       // Zero fill up to the minimum size
    Fcs
  } txState_t;

  // Nibble position inside the current field
  typedef logic [3:0] nibCnt_t;

  // Bytes since the destination address, also the gap length
  typedef logic [15:0] byteCnt_t;

endpackage

//--- verilog.f
ethFramePkg.sv
txStatePkg.sv
txFrameFsm.sv
txFieldSerializer.sv
txCrc32.sv
txOutputRegs.sv
txMacTop.sv
tbTxMac.sv
